/* hdl/bpred_pkg.sv */
package bpred_pkg;

    // Global history length and global/chooser table index width
    localparam int GHIST_LEN = 12;
    localparam int GPHT_BITS = 12;

    // Local history table index width
    localparam int BHT_BITS = 8;

    // Local history length, also the local counter table index width
    localparam int LHIST_LEN = 10;

    localparam int PC_BITS = 32;

    typedef logic [PC_BITS-1:0]   pc_t;
    typedef logic [GHIST_LEN-1:0] ghist_t;
    typedef logic [LHIST_LEN-1:0] lhist_t;
    typedef logic [GPHT_BITS-1:0] gidx_t;
    typedef logic [BHT_BITS-1:0]  bidx_t;

    // 2-bit saturating counter, taken when the high bit is set
    typedef logic [1:0] ctr_t;

    // Travels with a prediction and comes back with its commit
    typedef struct packed {
        gidx_t  g_index;
        gidx_t  c_index;
        bidx_t  b_index;
        lhist_t lhist;
        logic   g_taken;
        logic   l_taken;
    } pred_info_t;

    // Next value of a saturating counter
    function automatic ctr_t sat_ctr_next(input ctr_t ctr, input logic inc);
        ctr_t next;
        if (inc) begin
            next = (ctr == 2'b11) ? 2'b11 : ctr + 2'b01;
        end else begin
            next = (ctr == 2'b00) ? 2'b00 : ctr - 2'b01;
        end
        return next;
    endfunction

    // Shift a new outcome into a global history, newest in bit 0
    function automatic ghist_t ghist_shift(input ghist_t hist, input logic taken);
        return {hist[GHIST_LEN-2:0], taken};
    endfunction

    // Shift a new outcome into a local history, newest in bit 0
    function automatic lhist_t lhist_shift(input lhist_t hist, input logic taken);
        return {hist[LHIST_LEN-2:0], taken};
    endfunction

endpackage

/* hdl/global_hist_predictor.sv */
`timescale 1ns/1ps

module global_hist_predictor (
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_valid,
    input  bpred_pkg::pc_t    br_pc,
    input  logic              spec_valid,
    input  logic              spec_taken,
    input  logic              recover,
    input  logic              commit_valid,
    input  bpred_pkg::gidx_t  commit_index,
    input  logic              commit_taken,
    output bpred_pkg::gidx_t  g_index,
    output logic              g_taken,
    output bpred_pkg::ghist_t ghist
);

    localparam int GPHT_SIZE = 2 ** bpred_pkg::GPHT_BITS;

    bpred_pkg::ctr_t   pht [GPHT_SIZE];
    bpred_pkg::ghist_t ghist_spec;
    bpred_pkg::ghist_t ghist_commit;
    bpred_pkg::gidx_t  index_next;
    bpred_pkg::gidx_t  index_r;

    // Gshare hash of word-aligned PC and current speculative history
    assign index_next = br_pc[bpred_pkg::GPHT_BITS+1:2] ^ bpred_pkg::gidx_t'(ghist_spec);

    always_ff @(posedge clk) begin
        if (rst) begin
            index_r <= '0;
        end else if (pc_valid) begin
            index_r <= index_next;
        end
    end

    // Prediction read straight from the table in the cycle after pc_valid
    assign g_index = index_r;
    assign g_taken = pht[index_r][1];
    assign ghist   = ghist_spec;

    // Speculative history, restored from the committed copy on recover
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist_spec <= '0;
        end else if (recover) begin
            ghist_spec <= ghist_commit;
        end else if (spec_valid) begin
            ghist_spec <= bpred_pkg::ghist_shift(ghist_spec, spec_taken);
        end
    end

    // Committed history follows resolved outcomes only
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist_commit <= '0;
        end else if (commit_valid) begin
            ghist_commit <= bpred_pkg::ghist_shift(ghist_commit, commit_taken);
        end
    end

    // Counter training at commit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPHT_SIZE; i++) begin
                pht[i] <= '0;
            end
        end else if (commit_valid) begin
            pht[commit_index] <= bpred_pkg::sat_ctr_next(pht[commit_index], commit_taken);
        end
    end

endmodule

/* hdl/local_hist_predictor.sv */
`timescale 1ns/1ps

module local_hist_predictor (
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_valid,
    input  bpred_pkg::pc_t    br_pc,
    input  logic              commit_valid,
    input  bpred_pkg::bidx_t  commit_b_index,
    input  bpred_pkg::lhist_t commit_lhist,
    input  logic              commit_taken,
    output bpred_pkg::bidx_t  b_index,
    output bpred_pkg::lhist_t lhist,
    output logic              l_taken
);

    localparam int BHT_SIZE  = 2 ** bpred_pkg::BHT_BITS;
    localparam int LPHT_SIZE = 2 ** bpred_pkg::LHIST_LEN;

    // Per-branch history table and the counters it indexes
    bpred_pkg::lhist_t bht  [BHT_SIZE];
    bpred_pkg::ctr_t   lpht [LPHT_SIZE];

    bpred_pkg::bidx_t  b_index_r;
    bpred_pkg::lhist_t lhist_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            b_index_r <= '0;
        end else if (pc_valid) begin
            b_index_r <= br_pc[bpred_pkg::BHT_BITS+1:2];
        end
    end

    // Two chained table reads in the prediction cycle
    assign lhist_rd = bht[b_index_r];

    assign b_index = b_index_r;
    assign lhist   = lhist_rd;
    assign l_taken = lpht[lhist_rd][1];

    // Local history only moves at commit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_SIZE; i++) begin
                bht[i] <= '0;
            end
        end else if (commit_valid) begin
            // Shift into the stored entry so older in-flight copies cannot roll it back
            bht[commit_b_index] <= bpred_pkg::lhist_shift(bht[commit_b_index], commit_taken);
        end
    end

    // Train the counter the prediction actually used
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LPHT_SIZE; i++) begin
                lpht[i] <= '0;
            end
        end else if (commit_valid) begin
            lpht[commit_lhist] <= bpred_pkg::sat_ctr_next(lpht[commit_lhist], commit_taken);
        end
    end

endmodule

/* hdl/choice_predictor.sv */
`timescale 1ns/1ps

module choice_predictor (
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_valid,
    input  bpred_pkg::ghist_t ghist,
    input  logic              commit_valid,
    input  bpred_pkg::gidx_t  commit_index,
    input  logic              commit_g_taken,
    input  logic              commit_l_taken,
    input  logic              commit_taken,
    output bpred_pkg::gidx_t  c_index,
    output logic              prefer_global
);

    localparam int CPHT_SIZE = 2 ** bpred_pkg::GPHT_BITS;

    // Counter high bit set means trust the global predictor
    bpred_pkg::ctr_t  cpht [CPHT_SIZE];
    bpred_pkg::gidx_t index_r;
    logic             disagree;
    logic             global_right;

    always_ff @(posedge clk) begin
        if (rst) begin
            index_r <= '0;
        end else if (pc_valid) begin
            index_r <= bpred_pkg::gidx_t'(ghist);
        end
    end

    assign c_index       = index_r;
    assign prefer_global = cpht[index_r][1];

    // Train only when the components disagreed, so exactly one was right
    assign disagree     = commit_g_taken ^ commit_l_taken;
    assign global_right = (commit_g_taken == commit_taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CPHT_SIZE; i++) begin
                cpht[i] <= '0;
            end
        end else if (commit_valid && disagree) begin
            cpht[commit_index] <= bpred_pkg::sat_ctr_next(cpht[commit_index], global_right);
        end
    end

endmodule

/* hdl/tournament_predictor.sv */
`timescale 1ns/1ps

module tournament_predictor (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pc_valid,
    input  bpred_pkg::pc_t        br_pc,
    input  logic                  recover,
    input  logic                  commit_valid,
    input  bpred_pkg::pred_info_t commit_info,
    input  logic                  commit_taken,
    output logic                  pred_valid,
    output logic                  pred_taken,
    output bpred_pkg::pred_info_t pred_info,
    output bpred_pkg::ghist_t     ghist
);

    bpred_pkg::gidx_t  g_index;
    bpred_pkg::gidx_t  c_index;
    bpred_pkg::bidx_t  b_index;
    bpred_pkg::lhist_t lhist;
    logic              g_taken;
    logic              l_taken;
    logic              prefer_global;

    // One cycle from pc_valid to prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= pc_valid;
        end
    end

    // Final prediction also drives the speculative global history
    global_hist_predictor u_global (
        .clk          (clk),
        .rst          (rst),
        .pc_valid     (pc_valid),
        .br_pc        (br_pc),
        .spec_valid   (pred_valid),
        .spec_taken   (pred_taken),
        .recover      (recover),
        .commit_valid (commit_valid),
        .commit_index (commit_info.g_index),
        .commit_taken (commit_taken),
        .g_index      (g_index),
        .g_taken      (g_taken),
        .ghist        (ghist)
    );

    local_hist_predictor u_local (
        .clk            (clk),
        .rst            (rst),
        .pc_valid       (pc_valid),
        .br_pc          (br_pc),
        .commit_valid   (commit_valid),
        .commit_b_index (commit_info.b_index),
        .commit_lhist   (commit_info.lhist),
        .commit_taken   (commit_taken),
        .b_index        (b_index),
        .lhist          (lhist),
        .l_taken        (l_taken)
    );

    choice_predictor u_choice (
        .clk            (clk),
        .rst            (rst),
        .pc_valid       (pc_valid),
        .ghist          (ghist),
        .commit_valid   (commit_valid),
        .commit_index   (commit_info.c_index),
        .commit_g_taken (commit_info.g_taken),
        .commit_l_taken (commit_info.l_taken),
        .commit_taken   (commit_taken),
        .c_index        (c_index),
        .prefer_global  (prefer_global)
    );

    assign pred_taken = prefer_global ? g_taken : l_taken;

    always_comb begin
        pred_info.g_index = g_index;
        pred_info.c_index = c_index;
        pred_info.b_index = b_index;
        pred_info.lhist   = lhist;
        pred_info.g_taken = g_taken;
        pred_info.l_taken = l_taken;
    end

endmodule

/* dv/tournament_predictor_tb.sv */
`timescale 1ns/1ps

module tournament_predictor_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int POOL_SIZE     = 16;
    localparam int RAND_BRANCHES = 300;
    localparam int NUM_BRANCHES  = 4 + 44 + 6 + 40 + 39 + RAND_BRANCHES;
    localparam int GL = bpred_pkg::GHIST_LEN;
    localparam int LL = bpred_pkg::LHIST_LEN;

    // Expected and observed values of one prediction
    typedef struct packed {
        logic                  exp_taken;
        bpred_pkg::pred_info_t exp_info;
        bpred_pkg::ghist_t     exp_ghist;
        logic                  dut_taken;
        bpred_pkg::pred_info_t dut_info;
        bpred_pkg::ghist_t     dut_ghist;
    } pred_rec_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  pc_valid;
    bpred_pkg::pc_t        br_pc;
    logic                  recover;
    logic                  commit_valid;
    bpred_pkg::pred_info_t commit_info;
    logic                  commit_taken;
    logic                  pred_valid;
    logic                  pred_taken;
    bpred_pkg::pred_info_t pred_info;
    bpred_pkg::ghist_t     ghist;

    // Reference model state, always the state after the next rising edge
    bpred_pkg::ctr_t   model_gpht [2**bpred_pkg::GPHT_BITS];
    bpred_pkg::ctr_t   model_cpht [2**bpred_pkg::GPHT_BITS];
    bpred_pkg::ctr_t   model_lpht [2**LL];
    bpred_pkg::lhist_t model_bht  [2**bpred_pkg::BHT_BITS];
    bpred_pkg::ghist_t model_spec;
    bpred_pkg::ghist_t model_commit;
    bpred_pkg::gidx_t  model_gidx;
    bpred_pkg::gidx_t  model_cidx;
    bpred_pkg::bidx_t  model_bidx;
    logic              model_pred_valid;

    pred_rec_t pred_q [$];
    int        check_count = 0;
    int        error_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tournament_predictor DUT (
        .clk          (clk),
        .rst          (rst),
        .pc_valid     (pc_valid),
        .br_pc        (br_pc),
        .recover      (recover),
        .commit_valid (commit_valid),
        .commit_info  (commit_info),
        .commit_taken (commit_taken),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_info    (pred_info),
        .ghist        (ghist)
    );

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("ERROR time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
        end
    endtask

    function automatic bpred_pkg::ctr_t ctr_update(input bpred_pkg::ctr_t c, input logic up);
        if (up && c != 2'd3)
            return c + 2'd1;
        if (!up && c != 2'd0)
            return c - 2'd1;
        return c;
    endfunction

    function automatic void predict_ref(output logic taken, output bpred_pkg::pred_info_t info,
                                        output bpred_pkg::ghist_t gh);
        bpred_pkg::lhist_t lh;
        lh = model_bht[model_bidx];
        info.g_index = model_gidx;
        info.c_index = model_cidx;
        info.b_index = model_bidx;
        info.lhist   = lh;
        info.g_taken = model_gpht[model_gidx][1];
        info.l_taken = model_lpht[lh][1];
        // Chooser high bit picks the global component
        taken = model_cpht[model_cidx][1] ? info.g_taken : info.l_taken;
        gh = model_spec;
    endfunction

    task automatic reset_model();
        foreach (model_gpht[i]) model_gpht[i] = '0;
        foreach (model_cpht[i]) model_cpht[i] = '0;
        foreach (model_lpht[i]) model_lpht[i] = '0;
        foreach (model_bht[i]) model_bht[i] = '0;
        model_spec       = '0;
        model_commit     = '0;
        model_gidx       = '0;
        model_cidx       = '0;
        model_bidx       = '0;
        model_pred_valid = 1'b0;
    endtask

    // Apply the inputs of this cycle as the coming rising edge will
    task automatic update_model(input logic exp_taken);
        bpred_pkg::ghist_t old_spec;
        bpred_pkg::ghist_t old_commit;
        old_spec   = model_spec;
        old_commit = model_commit;
        if (pc_valid) begin
            model_gidx = br_pc[bpred_pkg::GPHT_BITS+1:2] ^ old_spec;
            model_cidx = old_spec;
            model_bidx = br_pc[bpred_pkg::BHT_BITS+1:2];
        end
        if (recover)
            model_spec = old_commit;
        else if (model_pred_valid)
            model_spec = {old_spec[GL-2:0], exp_taken};
        model_pred_valid = pc_valid;
        if (commit_valid) begin
            model_commit = {old_commit[GL-2:0], commit_taken};
            model_gpht[commit_info.g_index] =
                ctr_update(model_gpht[commit_info.g_index], commit_taken);
            model_lpht[commit_info.lhist] =
                ctr_update(model_lpht[commit_info.lhist], commit_taken);
            model_bht[commit_info.b_index] =
                {model_bht[commit_info.b_index][LL-2:0], commit_taken};
            if (commit_info.g_taken != commit_info.l_taken)
                model_cpht[commit_info.c_index] = ctr_update(model_cpht[commit_info.c_index],
                    commit_info.g_taken == commit_taken);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : compare_proc
        logic                  exp_taken;
        bpred_pkg::pred_info_t exp_info;
        bpred_pkg::ghist_t     exp_ghist;
        pred_rec_t             rec;
        if (rst) begin
            reset_model();
        end else begin
            compare_field("pred_valid", 32'(model_pred_valid), 32'(pred_valid));
            predict_ref(exp_taken, exp_info, exp_ghist);
            if (model_pred_valid) begin
                compare_field("pred_taken", 32'(exp_taken), 32'(pred_taken));
                compare_field("pred_info.g_index", 32'(exp_info.g_index), 32'(pred_info.g_index));
                compare_field("pred_info.c_index", 32'(exp_info.c_index), 32'(pred_info.c_index));
                compare_field("pred_info.b_index", 32'(exp_info.b_index), 32'(pred_info.b_index));
                compare_field("pred_info.lhist", 32'(exp_info.lhist), 32'(pred_info.lhist));
                compare_field("pred_info.g_taken", 32'(exp_info.g_taken), 32'(pred_info.g_taken));
                compare_field("pred_info.l_taken", 32'(exp_info.l_taken), 32'(pred_info.l_taken));
                compare_field("ghist", 32'(exp_ghist), 32'(ghist));
                rec = {exp_taken, exp_info, exp_ghist, pred_taken, pred_info, ghist};
                pred_q.push_back(rec);
            end
            update_model(exp_taken);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic predict_branch(input bpred_pkg::pc_t pc, output pred_rec_t rec);
        pc_valid = 1'b1;
        br_pc    = pc;
        next_cycle();
        pc_valid = 1'b0;
        while (pred_q.size() == 0)
            next_cycle();
        rec = pred_q.pop_front();
    endtask

    // Recover follows the commit of a mispredicted branch
    task automatic commit_branch(input pred_rec_t rec, input logic outcome);
        commit_valid = 1'b1;
        commit_info  = rec.exp_info;
        commit_taken = outcome;
        next_cycle();
        commit_valid = 1'b0;
        if (rec.exp_taken != outcome) begin
            recover = 1'b1;
            next_cycle();
            recover = 1'b0;
        end
    endtask

    task automatic run_branch(input bpred_pkg::pc_t pc, input logic outcome,
                              output pred_rec_t rec);
        predict_branch(pc, rec);
        commit_branch(rec, outcome);
    endtask

    task automatic run_burst(input int n, input bpred_pkg::pc_t pool [POOL_SIZE]);
        int        picks [4];
        pred_rec_t rec;
        logic      outcome;
        for (int k = 0; k < n; k++) begin
            picks[k] = int'($urandom % POOL_SIZE);
            pc_valid = 1'b1;
            br_pc    = pool[picks[k]];
            next_cycle();
        end
        pc_valid = 1'b0;
        while (pred_q.size() < n)
            next_cycle();
        for (int k = 0; k < n; k++) begin
            rec = pred_q.pop_front();
            // Odd pool entries lean not taken
            outcome = (($urandom % 4) != 0) ^ (picks[k] % 2 == 1);
            commit_branch(rec, outcome);
        end
    endtask

    initial begin
        pred_rec_t      rec;
        bpred_pkg::pc_t pool [POOL_SIZE];
        int             issued;
        int             burst;
        void'($urandom(32'h7efd_5ba8));
        rst          = 1'b1;
        pc_valid     = 1'b0;
        br_pc        = '0;
        recover      = 1'b0;
        commit_valid = 1'b0;
        commit_info  = '0;
        commit_taken = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_field("pred_valid after reset", 32'd0, 32'(pred_valid));

        // Cold tables predict not taken
        for (int i = 0; i < 4; i++) begin
            run_branch(32'h0000_0100 + 32'(i * 32'h104), 1'b0, rec);
            compare_field("pred_taken after reset", 32'd0, 32'(rec.dut_taken));
            compare_field("ghist after reset", 32'd0, 32'(rec.dut_ghist));
        end

        // Always taken, then always not taken
        for (int i = 0; i < 24; i++) begin
            run_branch(32'h0000_1040, 1'b1, rec);
            if (i >= 16)
                compare_field("l_taken always taken", 32'd1, 32'(rec.dut_info.l_taken));
        end
        for (int i = 0; i < 20; i++) begin
            run_branch(32'h0000_1040, 1'b0, rec);
            if (i >= 12)
                compare_field("l_taken never taken", 32'd0, 32'(rec.dut_info.l_taken));
        end

        // Speculative shift and recover to the committed history
        for (int i = 0; i < 6; i++) begin
            predict_branch(32'h0000_3318, rec);
            compare_field("ghist after shift",
                          32'({rec.exp_ghist[GL-2:0], rec.exp_taken}), 32'(ghist));
            commit_branch(rec, (i % 2 == 0) ? !rec.exp_taken : rec.exp_taken);
            if (i % 2 == 0)
                compare_field("ghist after recover", 32'(model_commit), 32'(ghist));
        end

        // Period-4 pattern learned by the local history
        for (int i = 0; i < 40; i++) begin
            run_branch(32'h0000_2a0c, (i % 4) != 3, rec);
            if (i >= 32)
                compare_field("l_taken period 4", 32'((i % 4) != 3),
                              32'(rec.dut_info.l_taken));
        end

        // Fresh taken branches fill ghist with ones and push the shared local counter
        // up, so a fresh not-taken branch finds global right and local wrong
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 12; k++)
                run_branch(32'h0000_0340 + 32'((r * 12 + k) * 4), 1'b1, rec);
            run_branch(32'h0000_3f00, 1'b0, rec);
            compare_field("l_taken chooser test", 32'd1, 32'(rec.dut_info.l_taken));
            // Chooser switches to global after two wins
            compare_field("pred_taken chooser test", 32'(r != 2), 32'(rec.dut_taken));
        end

        for (int k = 0; k < POOL_SIZE; k++)
            pool[k] = $urandom & 32'hffff_fffc;
        issued = 0;
        while (issued < RAND_BRANCHES) begin
            burst = 1 + int'($urandom % 4);
            run_burst(burst, pool);
            issued += burst;
        end

        next_cycle();
        next_cycle();
        $display("Checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #((NUM_BRANCHES * 10 + 200) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 NUM_BRANCHES * 10 + 200);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* list.f */
hdl/bpred_pkg.sv
hdl/global_hist_predictor.sv
hdl/local_hist_predictor.sv
hdl/choice_predictor.sv
hdl/tournament_predictor.sv
dv/tournament_predictor_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the tournament predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f list.f --top-module tournament_predictor_tb \
    -Mdir obj_dir -o tournament_predictor_sim \
    && ./obj_dir/tournament_predictor_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "RESULT: FAIL" "$LOG" \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
